//--- common/soc_map_pkg.sv
package soc_map_pkg;

    // on-chip RAM of 32-bit words
    localparam logic [63:0] ram_base  = 64'h0000_0000_8000_0000;
    localparam int unsigned ram_words = 2048;
    localparam int unsigned ram_idx_w = $clog2(ram_words);
    localparam logic [63:0] ram_limit = ram_base + 64'(ram_words * 4);

    // 8 MB SDRAM window
    localparam logic [63:0] sdram_min  = 64'h0000_0000_9000_0000;
    localparam logic [63:0] sdram_size = 64'h0000_0000_0080_0000;
    localparam logic [63:0] sdram_max  = sdram_min + sdram_size;

    // timer
    localparam logic [63:0] mtime_addr     = 64'h0000_0000_0200_BFF8;
    localparam logic [63:0] mtimecmp_addr  = 64'h0000_0000_0200_4000;
    localparam logic [63:0] mtimecmp_reset = 64'h0000_0000_8000_0000;

    // interrupt controller
    localparam logic [63:0] plic_base      = 64'h0000_0000_0C00_0000;
    localparam logic [63:0] plic_pending   = plic_base + 64'h1000;
    localparam logic [63:0] plic_enable    = plic_base + 64'h2000;
    localparam logic [63:0] plic_threshold = 64'h0000_0000_0C20_0000;
    localparam logic [63:0] plic_claim     = 64'h0000_0000_0C20_0004;
    localparam logic [63:0] plic_en_stride  = 64'h80;   // enable words per context
    localparam logic [63:0] plic_ctx_stride = 64'h1000; // threshold/claim per context
    localparam int unsigned plic_sources   = 6;

    typedef enum logic [2:0] {
        tgt_none, tgt_ram, tgt_sdram, tgt_mtime, tgt_mtimecmp, tgt_plic
    } target_t;

    typedef enum logic [3:0] {
        reg_priority, reg_pending, reg_enable0, reg_enable1,
        reg_thresh0, reg_thresh1, reg_claim0, reg_claim1, reg_none
    } plic_reg_t;

endpackage

//--- common/bus_pkg.sv
package bus_pkg;

    // load/store size and sign
    // stores only use the first four codes
    typedef enum logic [2:0] {
        ls_b  = 3'b000,
        ls_h  = 3'b001,
        ls_w  = 3'b010,
        ls_d  = 3'b011,
        ls_bu = 3'b100,
        ls_hu = 3'b101,
        ls_wu = 3'b110
    } ls_t;

    // CPU side request held stable until done
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        ls_t         ls;
        logic        read_en;  // one-cycle pulse
        logic        write_en; // one-cycle pulse
    } bus_req_t;

    // wait-request port towards the SDRAM controller
    typedef struct packed {
        logic [21:0] addr;    // halfword address
        logic [15:0] wdata;
        logic [1:0]  byte_en; // active high
        logic        read_en;
        logic        write_en;
    } sdram_req_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic        req_wait;
    } sdram_rsp_t;

endpackage

//--- source/addr_decoder.sv
`timescale 1ns/1ns

module addr_decoder (
    input  logic [63:0]             addr,
    output soc_map_pkg::target_t    target,
    output soc_map_pkg::plic_reg_t  plic_reg,
    output logic [2:0]              plic_id
);
    import soc_map_pkg::*;

    logic plic_hit;

    // one register per source in the priority array
    assign plic_id = addr[4:2];

    always_comb begin
        plic_hit = 1'b1;
        plic_reg = reg_none;
        if (addr >= plic_base && addr < plic_base + 64'(plic_sources * 4))
            plic_reg = reg_priority;
        else if (addr == plic_pending)
            plic_reg = reg_pending;
        else if (addr == plic_enable)
            plic_reg = reg_enable0;
        else if (addr == plic_enable + plic_en_stride)
            plic_reg = reg_enable1;
        else if (addr == plic_threshold)
            plic_reg = reg_thresh0;
        else if (addr == plic_threshold + plic_ctx_stride)
            plic_reg = reg_thresh1;
        else if (addr == plic_claim)
            plic_reg = reg_claim0;
        else if (addr == plic_claim + plic_ctx_stride)
            plic_reg = reg_claim1;
        else
            plic_hit = 1'b0;
    end

    always_comb begin
        target = tgt_none; // unmapped reads give zero
        if (addr >= ram_base && addr < ram_limit)
            target = tgt_ram;
        else if (addr >= sdram_min && addr < sdram_max)
            target = tgt_sdram;
        else if (addr == mtime_addr)
            target = tgt_mtime;
        else if (addr == mtimecmp_addr)
            target = tgt_mtimecmp;
        else if (plic_hit)
            target = tgt_plic;
    end

endmodule

//--- source/ram_port.sv
`timescale 1ns/1ns

module ram_port (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t bus,
    input  logic              start_read,
    input  logic              start_write,
    output logic [63:0]       rdata,
    output logic              finish
);
    import bus_pkg::*;
    import soc_map_pkg::*;

    logic [31:0]          mem [ram_words];
    logic [ram_idx_w-1:0] word_idx;
    logic [ram_idx_w-1:0] next_idx;
    logic                 upper_rd; // second step of ld pending
    logic                 upper_wr; // second step of sd pending

    assign word_idx = bus.addr[ram_idx_w+1:2];
    assign next_idx = word_idx + 1'b1;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            upper_rd <= 1'b0;
            upper_wr <= 1'b0;
            finish   <= 1'b0;
        end else begin
            finish <= 1'b0;
            if ((start_read || start_write) && bus.ls == ls_d) begin
                upper_rd <= start_read;
                upper_wr <= start_write;
            end else if (start_read || start_write) begin
                finish <= 1'b1;
            end else if (upper_rd || upper_wr) begin
                upper_rd <= 1'b0;
                upper_wr <= 1'b0;
                finish   <= 1'b1;
            end
        end
    end

    // storage and read data
    always_ff @(posedge CLOCK_50) begin
        if (start_read) begin
            if (bus.ls == ls_d)
                rdata[31:0] <= mem[word_idx];
            else
                rdata <= {32'b0, mem[word_idx] >> {bus.addr[1:0], 3'b000}};
        end
        if (upper_rd)
            rdata[63:32] <= mem[next_idx];

        if (start_write) begin
            case (bus.ls)
                ls_b:    mem[word_idx][{bus.addr[1:0], 3'b000} +: 8] <= bus.wdata[7:0];
                ls_h:    mem[word_idx][{bus.addr[1], 4'b0000} +: 16] <= bus.wdata[15:0];
                default: mem[word_idx] <= bus.wdata[31:0]; // sw, low word of sd
            endcase
        end
        if (upper_wr)
            mem[next_idx] <= bus.wdata[63:32];
    end

endmodule

//--- plic/plic_regs.sv
`timescale 1ns/1ns

module plic_regs (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   irq_src,
    input  soc_map_pkg::plic_reg_t reg_sel,
    input  logic [2:0]             id,
    input  logic [31:0]            wdata,
    input  logic                   wr,
    input  logic                   rd,
    output logic [31:0]            rdata,
    output logic                   meip,
    output logic                   msip
);
    import soc_map_pkg::*;

    logic [2:0]       prio [plic_sources];
    logic [31:0]      pending;
    logic [1:0][31:0] enable;
    logic [1:0][2:0]  thresh;
    logic             irq_q;
    logic [31:0]      claim0;
    logic [31:0]      claim1;

    // only source 1 is wired
    assign claim0 = (pending[1] && enable[0][1]) ? 32'd1 : 32'd0;
    assign claim1 = (pending[1] && enable[1][1]) ? 32'd1 : 32'd0;

    assign meip = (claim0 != 32'd0);
    assign msip = (claim1 != 32'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < plic_sources; i++)
                prio[i] <= 3'd0;
            pending <= 32'd0;
            enable  <= '0;
            thresh  <= '0;
            irq_q   <= 1'b0;
        end else begin
            irq_q <= irq_src;
            if (irq_src && !irq_q)
                pending[1] <= 1'b1; // rising edge only

            if (wr) begin
                case (reg_sel)
                    reg_priority: prio[id]  <= wdata[2:0];
                    reg_enable0:  enable[0] <= wdata;
                    reg_enable1:  enable[1] <= wdata;
                    reg_thresh0:  thresh[0] <= wdata[2:0];
                    reg_thresh1:  thresh[1] <= wdata[2:0];
                    default: ; // claim writes are ignored
                endcase
            end

            // claim read completes the interrupt
            if (rd && reg_sel == reg_claim0 && claim0 != 32'd0)
                pending[claim0[4:0]] <= 1'b0;
            if (rd && reg_sel == reg_claim1 && claim1 != 32'd0)
                pending[claim1[4:0]] <= 1'b0;
        end
    end

    always_comb begin
        rdata = 32'd0;
        case (reg_sel)
            reg_priority: if (id < plic_sources) rdata = {29'd0, prio[id]};
            reg_pending:  rdata = pending;
            reg_enable0:  rdata = enable[0];
            reg_enable1:  rdata = enable[1];
            reg_thresh0:  rdata = {29'd0, thresh[0]};
            reg_thresh1:  rdata = {29'd0, thresh[1]};
            reg_claim0:   rdata = claim0;
            reg_claim1:   rdata = claim1;
            default:      rdata = 32'd0;
        endcase
    end

endmodule

//--- sdram_bridge/sdram_bridge.sv
`timescale 1ns/1ns

module sdram_bridge (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  bus_pkg::bus_req_t   bus,
    input  logic                start_read,
    input  logic                start_write,
    output bus_pkg::sdram_req_t sdram_req,
    input  bus_pkg::sdram_rsp_t sdram_rsp,
    output logic [63:0]         rdata,
    output logic                finish
);
    import bus_pkg::*;

    logic        busy;
    logic        write_op;
    logic [1:0]  step;      // halfword index within the access
    logic [1:0]  last_step;
    logic        rd_en;
    logic        wr_en;
    logic        xfer_end;  // current transfer accepted
    logic [63:0] raw;       // halves collected low first
    logic [7:0]  byte_sel;

    // b/h take one transfer, w two, d four
    always_comb begin
        case (bus.ls[1:0])
            2'b11:   last_step = 2'd3;
            2'b10:   last_step = 2'd1;
            default: last_step = 2'd0;
        endcase
    end

    assign xfer_end = (rd_en || wr_en) && !sdram_rsp.req_wait;
    assign finish   = xfer_end && (step == last_step);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy     <= 1'b0;
            write_op <= 1'b0;
            step     <= 2'd0;
            rd_en    <= 1'b0;
            wr_en    <= 1'b0;
        end else if (!busy) begin
            if (start_read || start_write) begin
                busy     <= 1'b1;
                write_op <= start_write;
                step     <= 2'd0;
                rd_en    <= start_read;
                wr_en    <= start_write;
            end
        end else if (rd_en || wr_en) begin
            if (!sdram_rsp.req_wait) begin
                rd_en <= 1'b0; // one idle cycle between transfers
                wr_en <= 1'b0;
                if (step == last_step)
                    busy <= 1'b0;
                else
                    step <= step + 2'd1;
            end
        end else begin
            rd_en <= !write_op;
            wr_en <= write_op;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd_en && xfer_end)
            raw[{step, 4'b0000} +: 16] <= sdram_rsp.rdata;
    end

    always_comb begin
        sdram_req.addr     = bus.addr[22:1] + 22'(step);
        sdram_req.read_en  = rd_en;
        sdram_req.write_en = wr_en;
        if (bus.ls == ls_b || bus.ls == ls_bu) begin
            sdram_req.byte_en = bus.addr[0] ? 2'b10 : 2'b01;
            sdram_req.wdata   = {bus.wdata[7:0], bus.wdata[7:0]}; // byte in both lanes
        end else begin
            sdram_req.byte_en = 2'b11;
            sdram_req.wdata   = bus.wdata[{step, 4'b0000} +: 16];
        end
    end

    assign byte_sel = bus.addr[0] ? raw[15:8] : raw[7:0];

    // sign or zero extension by load type
    always_comb begin
        case (bus.ls)
            ls_b:    rdata = {{56{byte_sel[7]}}, byte_sel};
            ls_bu:   rdata = {56'd0, byte_sel};
            ls_h:    rdata = {{48{raw[15]}}, raw[15:0]};
            ls_hu:   rdata = {48'd0, raw[15:0]};
            ls_w:    rdata = {{32{raw[31]}}, raw[31:0]};
            ls_wu:   rdata = {32'd0, raw[31:0]};
            default: rdata = raw;
        endcase
    end

endmodule

//--- source/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  bus_pkg::bus_req_t   bus,
    input  logic [63:0]         mtime,
    input  logic                irq_src,
    input  bus_pkg::sdram_rsp_t sdram_rsp,
    output logic [63:0]         read_data,
    output logic                read_done,
    output logic                write_done,
    output logic                meip,
    output logic                msip,
    output bus_pkg::sdram_req_t sdram_req
);
    import soc_map_pkg::*;

    target_t     target;
    plic_reg_t   plic_reg;
    logic [2:0]  plic_id;
    logic [31:0] plic_rdata;
    logic [63:0] ram_rdata;
    logic [63:0] sdram_rdata;
    logic        ram_finish;
    logic        sdram_finish;
    logic [63:0] mtimecmp;
    logic [63:0] local_rdata; // registers served by the top itself
    logic        simple_tgt;
    logic        access_end;

    addr_decoder addr_decoder_i (
        .addr     (bus.addr),
        .target   (target),
        .plic_reg (plic_reg),
        .plic_id  (plic_id)
    );

    ram_port ram_port_i (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .bus         (bus),
        .start_read  (bus.read_en && target == tgt_ram),
        .start_write (bus.write_en && target == tgt_ram),
        .rdata       (ram_rdata),
        .finish      (ram_finish)
    );

    plic_regs plic_regs_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .irq_src  (irq_src),
        .reg_sel  (plic_reg),
        .id       (plic_id),
        .wdata    (bus.wdata[31:0]),
        .wr       (!write_done && target == tgt_plic),
        .rd       (!read_done && target == tgt_plic),
        .rdata    (plic_rdata),
        .meip     (meip),
        .msip     (msip)
    );

    sdram_bridge sdram_bridge_i (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .bus         (bus),
        .start_read  (bus.read_en && target == tgt_sdram),
        .start_write (bus.write_en && target == tgt_sdram),
        .sdram_req   (sdram_req),
        .sdram_rsp   (sdram_rsp),
        .rdata       (sdram_rdata),
        .finish      (sdram_finish)
    );

    // everything but RAM and SDRAM ends one cycle after done drops
    assign simple_tgt = (target != tgt_ram) && (target != tgt_sdram);
    assign access_end = simple_tgt ||
                        (target == tgt_ram && ram_finish) ||
                        (target == tgt_sdram && sdram_finish);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done   <= 1'b1;
            write_done  <= 1'b1;
            mtimecmp    <= mtimecmp_reset;
            local_rdata <= 64'd0;
        end else begin
            if (bus.read_en)
                read_done <= 1'b0;
            else if (!read_done && access_end)
                read_done <= 1'b1;

            if (bus.write_en)
                write_done <= 1'b0;
            else if (!write_done && access_end)
                write_done <= 1'b1;

            if (!read_done && simple_tgt) begin
                case (target)
                    tgt_mtime:    local_rdata <= mtime;
                    tgt_mtimecmp: local_rdata <= mtimecmp;
                    tgt_plic:     local_rdata <= {32'd0, plic_rdata};
                    default:      local_rdata <= 64'd0; // unmapped
                endcase
            end

            // mtime and unmapped writes just complete
            if (!write_done && target == tgt_mtimecmp)
                mtimecmp <= bus.wdata;
        end
    end

    always_comb begin
        case (target)
            tgt_ram:   read_data = ram_rdata;
            tgt_sdram: read_data = sdram_rdata;
            default:   read_data = local_rdata;
        endcase
    end

endmodule

//--- testbench/sdram_model.sv
`timescale 1ns/1ns

module sdram_model (
    input  logic                CLOCK_50,
    input  bus_pkg::sdram_req_t req,
    output bus_pkg::sdram_rsp_t rsp
);
    logic [15:0] mem [4096];   // low 12 bits of the halfword address
    logic [1:0]  wait_cnt;     // req_wait cycles left for this transfer
    logic        active;

    assign active       = req.read_en || req.write_en;
    assign rsp.req_wait = active && (wait_cnt != 2'd0);
    assign rsp.rdata    = mem[req.addr[11:0]];

    initial begin
        for (int i = 0; i < 4096; i++)
            mem[i] = 16'h0000;
        wait_cnt = 2'($urandom(32'h99f1da3b)); // seeds the generator once
        forever begin
            @(posedge CLOCK_50);
            if (!active) begin
                // new stretch drawn while the port is idle
                wait_cnt <= 2'($urandom_range(3, 0));
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else if (req.write_en) begin
                if (req.byte_en[0])
                    mem[req.addr[11:0]][7:0] <= req.wdata[7:0];
                if (req.byte_en[1])
                    mem[req.addr[11:0]][15:8] <= req.wdata[15:8];
            end
        end
    end

endmodule

//--- testbench/tb_soc_bus.sv
`timescale 1ns/1ns

module tb_soc_bus;
    import bus_pkg::*;

    localparam int          timeout_cycles = 200;
    localparam logic [63:0] mtime_value    = 64'h0123_4567_89ab_cdef;
    localparam logic [1:0]  irq_keep       = 2'd0;
    localparam logic [1:0]  irq_high       = 2'd1;
    localparam logic [1:0]  irq_low        = 2'd2;

    typedef struct packed {
        logic        wr;        // 0 load, 1 store
        ls_t         ls;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [1:0]  irq;       // irq_src change before the access
        logic [63:0] exp_data;
        logic        exp_meip;
        logic        exp_msip;
        logic [3:0]  exp_edges; // 0 for SDRAM where latency varies
    } row_t;

    logic        CLOCK_50;
    logic        KEY0;
    bus_req_t    bus;
    logic [63:0] mtime;
    logic        irq_src;
    sdram_rsp_t  sdram_rsp;
    sdram_req_t  sdram_req;
    logic [63:0] read_data;
    logic        read_done;
    logic        write_done;
    logic        meip;
    logic        msip;

    row_t rows [$];
    int   error_count;
    int   row_errs;
    int   tests_passed;
    int   tests_failed;

    soc_bus_top soc_bus_top_i (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus        (bus),
        .mtime      (mtime),
        .irq_src    (irq_src),
        .sdram_rsp  (sdram_rsp),
        .read_data  (read_data),
        .read_done  (read_done),
        .write_done (write_done),
        .meip       (meip),
        .msip       (msip),
        .sdram_req  (sdram_req)
    );

    sdram_model sdram_model_i (
        .CLOCK_50 (CLOCK_50),
        .req      (sdram_req),
        .rsp      (sdram_rsp)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // wait for the rising edge and then the drive point
    task automatic next_cycle();
        @(posedge CLOCK_50);
        #10;
    endtask

    task automatic add_row(input logic wr, input ls_t ls, input logic [63:0] addr,
                           input logic [63:0] wdata, input logic [1:0] irq,
                           input logic [63:0] exp_data, input logic exp_meip,
                           input logic exp_msip, input logic [3:0] exp_edges);
        rows.push_back({wr, ls, addr, wdata, irq, exp_data, exp_meip, exp_msip, exp_edges});
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp, input int idx);
        if (got !== exp) begin
            $display("Error row %0d: %s = 0x%h, expected 0x%h", idx, name, got, exp);
            row_errs++;
        end
    endtask

    task automatic check_reset_state();
        row_errs = 0;
        check_value("read_done", 64'(read_done), 64'h1, -1);
        check_value("write_done", 64'(write_done), 64'h1, -1);
        check_value("meip", 64'(meip), 64'h0, -1);
        check_value("msip", 64'(msip), 64'h0, -1);
        check_value("sdram_req.read_en", 64'(sdram_req.read_en), 64'h0, -1);
        check_value("sdram_req.write_en", 64'(sdram_req.write_en), 64'h0, -1);
        $display("reset state: %s", (row_errs == 0) ? "ok" : "FAILED");
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int   edges;
        logic done_seen;
        r = rows[idx];
        row_errs = 0;
        if (r.irq != irq_keep) begin
            irq_src = (r.irq == irq_high);
            repeat (3) next_cycle(); // let pending settle
        end
        bus.addr     = r.addr;
        bus.wdata    = r.wdata;
        bus.ls       = r.ls;
        bus.read_en  = !r.wr;
        bus.write_en = r.wr;
        edges = 0;
        done_seen = 1'b0;
        while (!done_seen && edges < timeout_cycles) begin
            next_cycle();
            edges++;
            if (edges == 1) begin
                bus.read_en  = 1'b0;
                bus.write_en = 1'b0;
                if (r.wr ? write_done : read_done) begin
                    $display("row %0d: done did not drop after the enable pulse", idx);
                    row_errs++;
                end
            end else if (r.wr ? write_done : read_done) begin
                done_seen = 1'b1;
            end
        end
        if (!done_seen) begin
            $display("row %0d: done never rose within %0d cycles", idx, timeout_cycles);
            row_errs++;
        end else begin
            if (r.exp_edges != 0 && edges != r.exp_edges) begin
                $display("row %0d: done rose on edge %0d instead of edge %0d",
                         idx, edges, r.exp_edges);
                row_errs++;
            end
            if (!r.wr)
                check_value("read_data", read_data, r.exp_data, idx);
            check_value("meip", 64'(meip), 64'(r.exp_meip), idx);
            check_value("msip", 64'(msip), 64'(r.exp_msip), idx);
        end
        $display("row %0d (%s addr 0x%h): %s", idx, r.wr ? "store" : "load",
                 r.addr, (row_errs == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        KEY0        = 1'b0;
        bus         = '0;
        mtime       = mtime_value;
        irq_src     = 1'b0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;

        // RAM sized stores and loads
        add_row(1, ls_w, 64'h8000_0010, 64'h1122_3344, irq_keep, 64'h0, 0, 0, 2);
        add_row(1, ls_b, 64'h8000_0011, 64'hab, irq_keep, 64'h0, 0, 0, 2);
        add_row(1, ls_h, 64'h8000_0012, 64'hcdef, irq_keep, 64'h0, 0, 0, 2);
        add_row(0, ls_w, 64'h8000_0010, 64'h0, irq_keep, 64'hcdef_ab44, 0, 0, 2);
        add_row(0, ls_bu, 64'h8000_0012, 64'h0, irq_keep, 64'hcdef, 0, 0, 2);
        // RAM double
        add_row(1, ls_d, 64'h8000_0020, 64'h0102_0304_0506_0708, irq_keep, 64'h0, 0, 0, 3);
        add_row(0, ls_d, 64'h8000_0020, 64'h0, irq_keep, 64'h0102_0304_0506_0708, 0, 0, 3);
        add_row(0, ls_w, 64'h8000_0024, 64'h0, irq_keep, 64'h0102_0304, 0, 0, 2);
        // SDRAM bridge under random wait
        add_row(1, ls_d, 64'h9000_0100, 64'hfedc_ba98_7654_3210, irq_keep, 64'h0, 0, 0, 0);
        add_row(0, ls_d, 64'h9000_0100, 64'h0, irq_keep, 64'hfedc_ba98_7654_3210, 0, 0, 0);
        add_row(1, ls_b, 64'h9000_0201, 64'h85, irq_keep, 64'h0, 0, 0, 0);
        add_row(0, ls_b, 64'h9000_0201, 64'h0, irq_keep, 64'hffff_ffff_ffff_ff85, 0, 0, 0);
        add_row(0, ls_bu, 64'h9000_0201, 64'h0, irq_keep, 64'h85, 0, 0, 0);
        // low lane untouched by the odd byte store
        add_row(0, ls_h, 64'h9000_0200, 64'h0, irq_keep, 64'hffff_ffff_ffff_8500, 0, 0, 0);
        add_row(1, ls_w, 64'h9000_0300, 64'h8765_4321, irq_keep, 64'h0, 0, 0, 0);
        add_row(0, ls_w, 64'h9000_0300, 64'h0, irq_keep, 64'hffff_ffff_8765_4321, 0, 0, 0);
        add_row(0, ls_wu, 64'h9000_0300, 64'h0, irq_keep, 64'h8765_4321, 0, 0, 0);
        // timer registers
        add_row(0, ls_d, 64'h0200_4000, 64'h0, irq_keep, 64'h8000_0000, 0, 0, 2);
        add_row(1, ls_d, 64'h0200_4000, 64'h42_0000_1000, irq_keep, 64'h0, 0, 0, 2);
        add_row(0, ls_d, 64'h0200_4000, 64'h0, irq_keep, 64'h42_0000_1000, 0, 0, 2);
        add_row(0, ls_d, 64'h0200_bff8, 64'h0, irq_keep, mtime_value, 0, 0, 2);
        // interrupt controller, source 1
        add_row(0, ls_w, 64'h0c00_1000, 64'h0, irq_keep, 64'h0, 0, 0, 2);
        add_row(1, ls_w, 64'h0c00_2000, 64'h2, irq_keep, 64'h0, 0, 0, 2);
        add_row(0, ls_w, 64'h0c00_1000, 64'h0, irq_high, 64'h2, 1, 0, 2);
        add_row(0, ls_w, 64'h0c20_0004, 64'h0, irq_keep, 64'h1, 0, 0, 2);
        add_row(1, ls_w, 64'h0c00_2080, 64'h2, irq_low, 64'h0, 0, 0, 2);
        add_row(0, ls_w, 64'h0c00_1000, 64'h0, irq_high, 64'h2, 1, 1, 2);
        add_row(1, ls_w, 64'h0c00_000c, 64'h5, irq_keep, 64'h0, 1, 1, 2);
        add_row(0, ls_w, 64'h0c00_000c, 64'h0, irq_keep, 64'h5, 1, 1, 2);
        // unmapped address
        add_row(0, ls_d, 64'h4000_0000, 64'h0, irq_keep, 64'h0, 1, 1, 2);
        add_row(1, ls_d, 64'h4000_0000, 64'hdead, irq_keep, 64'h0, 1, 1, 2);

        repeat (10) @(posedge CLOCK_50);
        #10;
        KEY0 = 1'b1;
        next_cycle();

        check_reset_state();
        error_count += row_errs;
        if (row_errs == 0)
            tests_passed++;
        else
            tests_failed++;

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
            error_count += row_errs;
            if (row_errs == 0)
                tests_passed++;
            else
                tests_failed++;
            next_cycle(); // idle cycle between accesses
        end

        $display("%0d tests: %0d passed, %0d failed, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- sim.f
common/soc_map_pkg.sv
common/bus_pkg.sv
source/addr_decoder.sv
source/ram_port.sv
plic/plic_regs.sv
sdram_bridge/sdram_bridge.sv
source/soc_bus_top.sv
testbench/sdram_model.sv
testbench/tb_soc_bus.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f sim.f \
    --top-module tb_soc_bus \
    -Mdir obj_dir -o tb_soc_bus

./obj_dir/tb_soc_bus > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
